/* board_periph_top.f */
+incdir+sim
hw/axil_pkg.sv
hw/board_cfg_pkg.sv
hw/axil_spill.sv
hw/board_regs.sv
hw/fan_pwm.sv
hw/rtc_divider.sv
hw/board_periph_top.sv
sim/tb_board_periph.sv

/* hw/axil_pkg.sv */
package axil_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite field types
  ////////////////////////////////////////////////////////////////////////////

  // 4 KiB register window
  typedef logic [11:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [2:0]  axil_prot_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t OKAY   = 2'b00;
  localparam axil_resp_t SLVERR = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // Request channel payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    axil_addr_t addr;
    axil_prot_t prot;
  } axil_aw_t;

  typedef struct packed {
    axil_addr_t addr;
    axil_prot_t prot;
  } axil_ar_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

endpackage

/* hw/axil_spill.sv */
`timescale 1ns/1ps

module axil_spill #(
  parameter type payload_t = logic
) (
  input  logic     soc_clk,
  input  logic     rst_n,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // Slot A takes new data, slot B holds what the sink refused
  logic     a_full_q;
  payload_t a_data_q;
  logic     b_full_q;
  payload_t b_data_q;

  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  assign a_fill  = in_valid_i & in_ready_o;
  // A leaves when it is presented, to the sink or into B
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~out_ready_i;
  assign b_drain = b_full_q & out_ready_i;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge soc_clk) begin
    if (a_fill) begin
      a_data_q <= in_data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Both sides see only flop outputs
  assign in_ready_o  = ~a_full_q | ~b_full_q;
  assign out_valid_o = a_full_q | b_full_q;
  assign out_data_o  = b_full_q ? b_data_q : a_data_q;

  // Stalled payload must not move, even while it shifts from A into B
  a_out_stable: assert property (@(posedge soc_clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

/* hw/board_cfg_pkg.sv */
package board_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam axil_pkg::axil_addr_t REG_ID_ADDR      = 12'h000;
  localparam axil_pkg::axil_addr_t REG_FAN_ADDR     = 12'h004;
  localparam axil_pkg::axil_addr_t REG_RTC_ADDR     = 12'h008;
  localparam axil_pkg::axil_addr_t REG_SCRATCH_ADDR = 12'h00C;

  // Board identification word
  localparam axil_pkg::axil_data_t BOARD_ID  = 32'hB0A2_D001;
  // Returned on reads that hit nothing
  localparam axil_pkg::axil_data_t ERR_VALUE = 32'hBADC_AB1E;

  ////////////////////////////////////////////////////////////////////////////
  // Fan PWM
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] fan_duty_t;

  localparam int unsigned FAN_STEPS      = 16;
  // soc_clk cycles per step, 64 cycle period
  localparam int unsigned FAN_PRESCALE   = 4;
  localparam int unsigned FAN_STEP_W     = $clog2(FAN_STEPS);
  localparam int unsigned FAN_PRESCALE_W = $clog2(FAN_PRESCALE);

  ////////////////////////////////////////////////////////////////////////////
  // RTC divider
  ////////////////////////////////////////////////////////////////////////////

  // Half period in soc_clk cycles, 10 cycle RTC period
  localparam int unsigned RTC_HALF_PERIOD = 5;
  localparam int unsigned RTC_DIV_W       = $clog2(RTC_HALF_PERIOD);

endpackage

/* hw/board_periph_top.sv */
`timescale 1ns/1ps

module board_periph_top (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  s_awvalid_i,
  output logic                  s_awready_o,
  input  axil_pkg::axil_addr_t  s_awaddr_i,
  input  axil_pkg::axil_prot_t  s_awprot_i,
  input  logic                  s_wvalid_i,
  output logic                  s_wready_o,
  input  axil_pkg::axil_data_t  s_wdata_i,
  input  axil_pkg::axil_strb_t  s_wstrb_i,
  output logic                  s_bvalid_o,
  input  logic                  s_bready_i,
  output axil_pkg::axil_resp_t  s_bresp_o,
  input  logic                  s_arvalid_i,
  output logic                  s_arready_o,
  input  axil_pkg::axil_addr_t  s_araddr_i,
  input  axil_pkg::axil_prot_t  s_arprot_i,
  output logic                  s_rvalid_o,
  input  logic                  s_rready_i,
  output axil_pkg::axil_data_t  s_rdata_o,
  output axil_pkg::axil_resp_t  s_rresp_o,
  output logic                  fan_pwm_o,
  output logic                  rtc_clk_o
);

  import axil_pkg::*;
  import board_cfg_pkg::*;

  axil_aw_t   aw_in;
  axil_w_t    w_in;
  axil_ar_t   ar_in;

  logic       aw_valid;
  logic       aw_ready;
  axil_aw_t   aw;
  logic       w_valid;
  logic       w_ready;
  axil_w_t    w;
  logic       ar_valid;
  logic       ar_ready;
  axil_ar_t   ar;

  fan_duty_t  fan_duty;
  logic       rtc_clear;
  axil_data_t rtc_count;

  ////////////////////////////////////////////////////////////////////////////
  // Request spills
  ////////////////////////////////////////////////////////////////////////////

  assign aw_in = '{addr: s_awaddr_i, prot: s_awprot_i};
  assign w_in  = '{data: s_wdata_i, strb: s_wstrb_i};
  assign ar_in = '{addr: s_araddr_i, prot: s_arprot_i};

  axil_spill #(.payload_t(axil_aw_t)) u_aw_spill (
    .soc_clk     (soc_clk),
    .rst_n       (rst_n),
    .in_valid_i  (s_awvalid_i),
    .in_ready_o  (s_awready_o),
    .in_data_i   (aw_in),
    .out_valid_o (aw_valid),
    .out_ready_i (aw_ready),
    .out_data_o  (aw)
  );

  axil_spill #(.payload_t(axil_w_t)) u_w_spill (
    .soc_clk     (soc_clk),
    .rst_n       (rst_n),
    .in_valid_i  (s_wvalid_i),
    .in_ready_o  (s_wready_o),
    .in_data_i   (w_in),
    .out_valid_o (w_valid),
    .out_ready_i (w_ready),
    .out_data_o  (w)
  );

  axil_spill #(.payload_t(axil_ar_t)) u_ar_spill (
    .soc_clk     (soc_clk),
    .rst_n       (rst_n),
    .in_valid_i  (s_arvalid_i),
    .in_ready_o  (s_arready_o),
    .in_data_i   (ar_in),
    .out_valid_o (ar_valid),
    .out_ready_i (ar_ready),
    .out_data_o  (ar)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register block and board blocks
  ////////////////////////////////////////////////////////////////////////////

  board_regs u_regs (
    .soc_clk     (soc_clk),
    .rst_n       (rst_n),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_i        (aw),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_i         (w),
    .b_valid_o   (s_bvalid_o),
    .b_ready_i   (s_bready_i),
    .b_resp_o    (s_bresp_o),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_i        (ar),
    .r_valid_o   (s_rvalid_o),
    .r_ready_i   (s_rready_i),
    .r_data_o    (s_rdata_o),
    .r_resp_o    (s_rresp_o),
    .rtc_count_i (rtc_count),
    .fan_duty_o  (fan_duty),
    .rtc_clear_o (rtc_clear)
  );

  fan_pwm u_fan_pwm (
    .soc_clk (soc_clk),
    .rst_n   (rst_n),
    .duty_i  (fan_duty),
    .pwm_o   (fan_pwm_o)
  );

  rtc_divider u_rtc_divider (
    .soc_clk   (soc_clk),
    .rst_n     (rst_n),
    .clear_i   (rtc_clear),
    .rtc_clk_o (rtc_clk_o),
    .count_o   (rtc_count)
  );

endmodule

/* hw/board_regs.sv */
`timescale 1ns/1ps

module board_regs (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  axil_pkg::axil_aw_t        aw_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  input  axil_pkg::axil_w_t         w_i,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  output axil_pkg::axil_resp_t      b_resp_o,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  axil_pkg::axil_ar_t        ar_i,
  output logic                      r_valid_o,
  input  logic                      r_ready_i,
  output axil_pkg::axil_data_t      r_data_o,
  output axil_pkg::axil_resp_t      r_resp_o,
  input  axil_pkg::axil_data_t      rtc_count_i,
  output board_cfg_pkg::fan_duty_t  fan_duty_o,
  output logic                      rtc_clear_o
);

  import axil_pkg::*;
  import board_cfg_pkg::*;

  logic       wr_fire;
  logic       rd_fire;
  axil_resp_t wr_resp;
  axil_data_t rd_data;
  axil_resp_t rd_resp;

  logic       b_valid_q;
  axil_resp_t b_resp_q;
  logic       r_valid_q;
  axil_data_t r_data_q;
  axil_resp_t r_resp_q;
  fan_duty_t  fan_duty_q;
  axil_data_t scratch_q;
  logic       rtc_clear_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // AW and W are taken together, one B outstanding at a time
  assign wr_fire    = aw_valid_i & w_valid_i & ~b_valid_q;
  assign aw_ready_o = wr_fire;
  assign w_ready_o  = wr_fire;

  assign rd_fire    = ar_valid_i & ~r_valid_q;
  assign ar_ready_o = rd_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // ID is read-only, so writes to it fall into the error case
  always_comb begin
    case (aw_i.addr)
      REG_FAN_ADDR,
      REG_RTC_ADDR,
      REG_SCRATCH_ADDR: wr_resp = OKAY;
      default:          wr_resp = SLVERR;
    endcase
  end

  always_comb begin
    rd_resp = OKAY;
    case (ar_i.addr)
      REG_ID_ADDR:      rd_data = BOARD_ID;
      REG_FAN_ADDR:     rd_data = axil_data_t'(fan_duty_q);
      REG_RTC_ADDR:     rd_data = rtc_count_i;
      REG_SCRATCH_ADDR: rd_data = scratch_q;
      default: begin
        rd_data = ERR_VALUE;
        rd_resp = SLVERR;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid_q   <= 1'b0;
      r_valid_q   <= 1'b0;
      rtc_clear_q <= 1'b0;
      fan_duty_q  <= '0;
      scratch_q   <= '0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      // Any write to RTC clears the tick count
      rtc_clear_q <= wr_fire && (aw_i.addr == REG_RTC_ADDR);
      if (wr_fire && (aw_i.addr == REG_FAN_ADDR) && w_i.strb[0]) begin
        fan_duty_q <= w_i.data[$bits(fan_duty_t)-1:0];
      end
      if (wr_fire && (aw_i.addr == REG_SCRATCH_ADDR)) begin
        for (int i = 0; i < $bits(axil_strb_t); i++) begin
          if (w_i.strb[i]) begin
            scratch_q[8*i +: 8] <= w_i.data[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge soc_clk) begin
    if (wr_fire) begin
      b_resp_q <= wr_resp;
    end
    if (rd_fire) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  assign b_valid_o   = b_valid_q;
  assign b_resp_o    = b_resp_q;
  assign r_valid_o   = r_valid_q;
  assign r_data_o    = r_data_q;
  assign r_resp_o    = r_resp_q;
  assign fan_duty_o  = fan_duty_q;
  assign rtc_clear_o = rtc_clear_q;

  // Responses are held until the master takes them
  a_b_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o));
  a_r_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

/* hw/fan_pwm.sv */
`timescale 1ns/1ps

module fan_pwm (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  board_cfg_pkg::fan_duty_t  duty_i,
  output logic                      pwm_o
);

  import board_cfg_pkg::*;

  logic [FAN_PRESCALE_W-1:0] presc_q;
  logic [FAN_STEP_W-1:0]     step_q;
  fan_duty_t                 duty_q;
  logic                      pwm_q;

  logic                      step_tick;
  logic [FAN_STEP_W-1:0]     step_next;
  fan_duty_t                 duty_next;

  assign step_tick = (presc_q == FAN_PRESCALE_W'(FAN_PRESCALE - 1));
  assign step_next = (step_q == FAN_STEP_W'(FAN_STEPS - 1)) ? '0 : step_q + 1'b1;
  // New duty only at a period start
  assign duty_next = (step_next == '0) ? duty_i : duty_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
      duty_q  <= '0;
      pwm_q   <= 1'b0;
    end else begin
      if (step_tick) begin
        presc_q <= '0;
        step_q  <= step_next;
        duty_q  <= duty_next;
        // High for the first duty steps, so duty 0 stays off
        pwm_q   <= (step_next < duty_next);
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

  assign pwm_o = pwm_q;

endmodule

/* hw/rtc_divider.sv */
`timescale 1ns/1ps

module rtc_divider (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  input  logic                  clear_i,
  output logic                  rtc_clk_o,
  output axil_pkg::axil_data_t  count_o
);

  import axil_pkg::*;
  import board_cfg_pkg::*;

  logic [RTC_DIV_W-1:0] half_cnt_q;
  logic                 rtc_clk_q;
  axil_data_t           count_q;
  logic                 half_done;

  assign half_done = (half_cnt_q == RTC_DIV_W'(RTC_HALF_PERIOD - 1));

  // Clock phase runs free of clear_i
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt_q <= '0;
      rtc_clk_q  <= 1'b0;
    end else if (half_done) begin
      half_cnt_q <= '0;
      rtc_clk_q  <= ~rtc_clk_q;
    end else begin
      half_cnt_q <= half_cnt_q + 1'b1;
    end
  end

  // Tick on each rising edge of the RTC clock
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (half_done && !rtc_clk_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign rtc_clk_o = rtc_clk_q;
  assign count_o   = count_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the board peripheral testbench with Verilator.
# The log decides the verdict; the simulator exit code alone does not.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_board_periph \
  -f board_periph_top.f

./obj_dir/Vtb_board_periph > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation ended without a verdict, see sim.log"
  exit 1
fi
echo "Simulation passed"

/* sim/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// Stops the run at the first mismatch
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
  if (got !== exp) begin
    $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
    $display("Test failed");
    $fatal(1, "mismatch on %s", name);
  end
endtask

// Called on a falling edge, returns on a falling edge
task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                         input axil_strb_t strb, input int max_stall,
                         output axil_resp_t resp, output int hs_cycle);
  int   stall;
  logic aw_fire;
  logic w_fire;
  stall      = (max_stall > 0) ? int'($urandom % (max_stall + 1)) : 0;
  s_awaddr   = addr;
  s_wdata    = data;
  s_wstrb    = strb;
  s_awvalid  = 1'b1;
  s_wvalid   = 1'b1;
  // AW and W complete on their own
  while (s_awvalid || s_wvalid) begin
    aw_fire = s_awvalid & s_awready;
    w_fire  = s_wvalid & s_wready;
    @(negedge soc_clk);
    if (aw_fire) begin
      s_awvalid = 1'b0;
    end
    if (w_fire) begin
      s_wvalid = 1'b0;
    end
  end
  repeat (stall) @(negedge soc_clk);
  s_bready = 1'b1;
  while (!s_bvalid) @(negedge soc_clk);
  resp     = s_bresp;
  hs_cycle = cycle_cnt;
  @(negedge soc_clk);
  s_bready = 1'b0;
endtask

task automatic read_reg(input axil_addr_t addr, input int max_stall,
                        output axil_data_t data, output axil_resp_t resp,
                        output int hs_cycle);
  int stall;
  stall     = (max_stall > 0) ? int'($urandom % (max_stall + 1)) : 0;
  s_araddr  = addr;
  s_arvalid = 1'b1;
  while (!s_arready) @(negedge soc_clk);
  @(negedge soc_clk);
  s_arvalid = 1'b0;
  repeat (stall) @(negedge soc_clk);
  s_rready = 1'b1;
  while (!s_rvalid) @(negedge soc_clk);
  data     = s_rdata;
  resp     = s_rresp;
  hs_cycle = cycle_cnt;
  @(negedge soc_clk);
  s_rready = 1'b0;
endtask

`endif

/* sim/tb_board_periph.sv */
`timescale 1ns/1ps

module tb_board_periph;

  import axil_pkg::*;
  import board_cfg_pkg::*;

  typedef struct packed {
    logic       is_write;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    axil_resp_t resp;
    axil_data_t rdata;
  } entry_t;

  localparam int MAX_STALL  = 3;
  localparam int PWM_PERIOD = FAN_STEPS * FAN_PRESCALE;

  logic       soc_clk;
  logic       rst_n;
  logic       s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic       s_arvalid, s_arready, s_rvalid, s_rready;
  axil_addr_t s_awaddr, s_araddr;
  axil_data_t s_wdata, s_rdata;
  axil_strb_t s_wstrb;
  axil_resp_t s_bresp, s_rresp;
  logic       fan_pwm, rtc_clk;

  int unsigned cycle_cnt = 0;
  int unsigned timeout_limit;
  entry_t      stim_q[$];

  `include "tb_axil_tasks.svh"

  board_periph_top u_dut (
    .soc_clk (soc_clk), .rst_n (rst_n),
    .s_awvalid_i (s_awvalid), .s_awready_o (s_awready),
    .s_awaddr_i (s_awaddr), .s_awprot_i (3'b000),
    .s_wvalid_i (s_wvalid), .s_wready_o (s_wready),
    .s_wdata_i (s_wdata), .s_wstrb_i (s_wstrb),
    .s_bvalid_o (s_bvalid), .s_bready_i (s_bready), .s_bresp_o (s_bresp),
    .s_arvalid_i (s_arvalid), .s_arready_o (s_arready),
    .s_araddr_i (s_araddr), .s_arprot_i (3'b000),
    .s_rvalid_o (s_rvalid), .s_rready_i (s_rready),
    .s_rdata_o (s_rdata), .s_rresp_o (s_rresp),
    .fan_pwm_o (fan_pwm), .rtc_clk_o (rtc_clk)
  );

  always #4 soc_clk = ~soc_clk;

  always @(posedge soc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic void add_entry(logic is_write, axil_addr_t addr, axil_data_t data,
                                    axil_strb_t strb, axil_resp_t resp, axil_data_t rdata);
    stim_q.push_back('{is_write, addr, data, strb, resp, rdata});
  endfunction

  // Steady state high time over one full PWM period
  task automatic pwm_duty_test(input int duty);
    int high_cnt;
    high_cnt = 0;
    repeat (2 * PWM_PERIOD) @(negedge soc_clk);
    repeat (PWM_PERIOD) begin
      @(negedge soc_clk);
      if (fan_pwm) begin
        high_cnt++;
      end
    end
    check_value("fan_pwm_o high cycles", high_cnt, duty * FAN_PRESCALE);
  endtask

  task automatic rtc_test();
    int         high_cnt;
    int         low_cnt;
    int         b_cycle;
    int         r_cycle;
    int         n;
    axil_resp_t resp;
    axil_data_t count;
    high_cnt = 0;
    low_cnt  = 0;
    while (rtc_clk) @(negedge soc_clk);
    while (!rtc_clk) @(negedge soc_clk);
    while (rtc_clk) begin
      high_cnt++;
      @(negedge soc_clk);
    end
    while (!rtc_clk) begin
      low_cnt++;
      @(negedge soc_clk);
    end
    check_value("rtc_clk_o high cycles", high_cnt, RTC_HALF_PERIOD);
    check_value("rtc_clk_o low cycles", low_cnt, RTC_HALF_PERIOD);
    write_reg(REG_RTC_ADDR, 32'h0, 4'hF, 0, resp, b_cycle);
    check_value("s_bresp_o rtc clear", resp, OKAY);
    // Gap puts the sample midway between two RTC ticks
    repeat (42) @(negedge soc_clk);
    read_reg(REG_RTC_ADDR, 0, count, resp, r_cycle);
    check_value("s_rresp_o rtc", resp, OKAY);
    n = r_cycle - b_cycle;
    if (count != n / (2 * RTC_HALF_PERIOD)) begin
      check_value("s_rdata_o rtc count", count,
                  (n + 2 * RTC_HALF_PERIOD - 1) / (2 * RTC_HALF_PERIOD));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    entry_t     e;
    axil_resp_t resp;
    axil_data_t rdata;
    int         hs;
    void'($urandom(91));
    soc_clk   = 1'b0;
    rst_n     = 1'b0;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    s_awaddr  = '0;
    s_araddr  = '0;
    s_wdata   = '0;
    s_wstrb   = '0;

    add_entry(0, REG_ID_ADDR,      32'h0,         4'h0, OKAY,   BOARD_ID);
    add_entry(1, REG_ID_ADDR,      32'h1234_5678, 4'hF, SLVERR, 32'h0);
    add_entry(0, REG_ID_ADDR,      32'h0,         4'h0, OKAY,   BOARD_ID);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h0000_0000);
    add_entry(1, REG_SCRATCH_ADDR, 32'h1122_3344, 4'hF, OKAY,   32'h0);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h1122_3344);
    add_entry(1, REG_SCRATCH_ADDR, 32'hAABB_CCDD, 4'h5, OKAY,   32'h0);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h11BB_33DD);
    add_entry(1, REG_SCRATCH_ADDR, 32'h5566_7788, 4'hA, OKAY,   32'h0);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h55BB_77DD);
    add_entry(1, REG_SCRATCH_ADDR, 32'hFFFF_FFFF, 4'h0, OKAY,   32'h0);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h55BB_77DD);
    add_entry(1, REG_SCRATCH_ADDR, 32'h00EE_0000, 4'h4, OKAY,   32'h0);
    add_entry(0, REG_SCRATCH_ADDR, 32'h0,         4'h0, OKAY,   32'h55EE_77DD);
    add_entry(0, 12'h010,          32'h0,         4'h0, SLVERR, ERR_VALUE);
    add_entry(0, 12'hFFC,          32'h0,         4'h0, SLVERR, ERR_VALUE);
    add_entry(1, 12'h010,          32'hDEAD_0000, 4'hF, SLVERR, 32'h0);
    add_entry(1, 12'h804,          32'h0000_0001, 4'h1, SLVERR, 32'h0);
    // Each FAN read also runs the PWM check
    add_entry(1, REG_FAN_ADDR,     32'h0,         4'h1, OKAY,   32'h0);
    add_entry(0, REG_FAN_ADDR,     32'h0,         4'h0, OKAY,   32'd0);
    add_entry(1, REG_FAN_ADDR,     32'h0000_0005, 4'h1, OKAY,   32'h0);
    add_entry(0, REG_FAN_ADDR,     32'h0,         4'h0, OKAY,   32'd5);
    add_entry(1, REG_FAN_ADDR,     32'hFFFF_FF0F, 4'h1, OKAY,   32'h0);
    add_entry(0, REG_FAN_ADDR,     32'h0,         4'h0, OKAY,   32'd15);
    timeout_limit = stim_q.size() * 20 + 4 * PWM_PERIOD + 200;

    repeat (10) @(negedge soc_clk);
    rst_n = 1'b1;
    @(negedge soc_clk);

    foreach (stim_q[i]) begin
      e = stim_q[i];
      if (e.is_write) begin
        write_reg(e.addr, e.data, e.strb, MAX_STALL, resp, hs);
        check_value($sformatf("s_bresp_o entry %0d", i), resp, e.resp);
      end else begin
        read_reg(e.addr, MAX_STALL, rdata, resp, hs);
        check_value($sformatf("s_rresp_o entry %0d", i), resp, e.resp);
        check_value($sformatf("s_rdata_o entry %0d", i), rdata, e.rdata);
        if (e.addr == REG_FAN_ADDR) begin
          pwm_duty_test(e.rdata);
        end
      end
    end

    rtc_test();

    $display("Test completed successfully");
    $finish;
  end

endmodule
